// File: hdl/lc3b_types.sv
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    typedef logic [3:0]  lc3b_imm4;
    typedef logic [4:0]  lc3b_imm5;
    typedef logic [5:0]  lc3b_offset6;
    typedef logic [8:0]  lc3b_offset9;
    typedef logic [10:0] lc3b_offset11;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    typedef enum logic [1:0] {
        pcmux_plus2  = 2'b00,
        pcmux_branch = 2'b01,
        pcmux_base   = 2'b10
    } pcmux_sel_t;

    typedef enum logic [2:0] {
        alumux_reg   = 3'b000,
        alumux_sext5 = 3'b001,
        alumux_adj6  = 3'b010,
        alumux_zext4 = 3'b011
    } alumux_sel_t;

    typedef enum logic [1:0] {
        rfmux_alu   = 2'b00,
        rfmux_mdr   = 2'b01,
        rfmux_bradd = 2'b10,
        rfmux_pc    = 2'b11
    } regfilemux_sel_t;

    localparam lc3b_word reset_pc = 16'h0000;
    localparam lc3b_reg  link_reg = 3'd7;

endpackage : lc3b_types

`default_nettype wire

// File: hdl/ir.sv
`timescale 1ns/1ps
`default_nettype none

module ir
    import lc3b_types::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         load,
    input  lc3b_word     in,
    output lc3b_opcode   opcode,
    output logic         inst4,
    output logic         inst5,
    output logic         inst11,
    output lc3b_reg      dest,
    output lc3b_reg      src1,
    output lc3b_reg      src2,
    output lc3b_imm4     imm4,
    output lc3b_imm5     imm5,
    output lc3b_offset6  offset6,
    output lc3b_offset9  offset9,
    output lc3b_offset11 offset11
);

    lc3b_word data;

    always_ff @(posedge clk) begin
        if (reset) begin
            data <= 16'h0000;  // BR with nzp clear never branches
        end else if (load) begin
            data <= in;
        end
    end

    assign opcode   = lc3b_opcode'(data[15:12]);
    assign dest     = data[11:9];  // Also the nzp mask of a branch
    assign src1     = data[8:6];
    assign src2     = data[2:0];
    assign inst4    = data[4];
    assign inst5    = data[5];
    assign inst11   = data[11];
    assign imm4     = data[3:0];
    assign imm5     = data[4:0];
    assign offset6  = data[5:0];
    assign offset9  = data[8:0];
    assign offset11 = data[10:0];

endmodule : ir

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  lc3b_word in,
    input  lc3b_reg  src_a,
    input  lc3b_reg  src_b,
    input  lc3b_reg  dest,
    output lc3b_word reg_a,
    output lc3b_word reg_b
);

    lc3b_word data [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                data[i] <= 16'h0000;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    assign reg_a = data[src_a];  // No bypass, a write shows up one cycle later
    assign reg_b = data[src_b];

endmodule : regfile

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import lc3b_types::*;
(
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_and:  f = a & b;
            alu_not:  f = ~a;
            alu_pass: f = b;
            alu_sll:  f = a << shamt;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = lc3b_word'($signed(a) >>> shamt);
            default:  f = a;
        endcase
    end

endmodule : alu

`default_nettype wire

// File: hdl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
    import lc3b_types::*;
(
    input  logic            clk,
    input  logic            reset,

    input  lc3b_word        mem_rdata,
    input  logic            mem_resp,

    input  logic            load_pc,
    input  logic            load_ir,
    input  logic            load_regfile,
    input  logic            load_mar,
    input  logic            load_mdr,
    input  logic            load_cc,
    input  pcmux_sel_t      pcmux_sel,
    input  logic            storemux_sel,
    input  logic            destmux_sel,
    input  alumux_sel_t     alumux_sel,
    input  regfilemux_sel_t regfilemux_sel,
    input  logic            marmux_sel,
    input  logic            mdrmux_sel,
    input  lc3b_aluop       aluop,

    output lc3b_word        mem_address,
    output lc3b_word        mem_wdata,

    output lc3b_opcode      opcode,
    output logic            inst4,
    output logic            inst5,
    output logic            inst11,
    output logic            branch_enable
);

    lc3b_reg      dest, src1, src2;
    lc3b_reg      storemux_out, destmux_out;
    lc3b_imm4     imm4;
    lc3b_imm5     imm5;
    lc3b_offset6  offset6;
    lc3b_offset9  offset9;
    lc3b_offset11 offset11;

    lc3b_word pc, pc_plus2, pcmux_out;
    lc3b_word adj6, adj9, adj11, sext5, zext4;
    lc3b_word br_offset, bradd_out;
    lc3b_word sr1_out, sr2_out, alumux_out, alu_out;
    lc3b_word regfilemux_out, marmux_out, mdrmux_out;
    lc3b_word mar, mdr;
    lc3b_nzp  gencc, cc;
    logic     mdr_load_en;

    assign adj6  = {{9{offset6[5]}}, offset6, 1'b0};
    assign adj9  = {{6{offset9[8]}}, offset9, 1'b0};
    assign adj11 = {{4{offset11[10]}}, offset11, 1'b0};
    assign sext5 = {{11{imm5[4]}}, imm5};
    assign zext4 = {12'h000, imm4};

    // PC and branch target
    assign pc_plus2  = pc + 16'd2;
    assign br_offset = (opcode == op_jsr) ? adj11 : adj9;  // JSR carries an 11 bit offset
    assign bradd_out = pc + br_offset;

    always_comb begin
        case (pcmux_sel)
            pcmux_branch: pcmux_out = bradd_out;
            pcmux_base:   pcmux_out = sr1_out;
            default:      pcmux_out = pc_plus2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (load_pc) begin
            pc <= pcmux_out;
        end
    end

    // Memory address and data registers
    assign marmux_out  = marmux_sel ? pc : alu_out;
    assign mdrmux_out  = mdrmux_sel ? mem_rdata : alu_out;
    assign mdr_load_en = load_mdr & (~mdrmux_sel | mem_resp);  // Read data lands on response

    always_ff @(posedge clk) begin
        if (load_mar) begin
            mar <= marmux_out;
        end
        if (mdr_load_en) begin
            mdr <= mdrmux_out;
        end
    end

    assign mem_address = mar;
    assign mem_wdata   = mdr;

    ir u_ir (
        .clk,
        .reset,
        .load(load_ir),
        .in(mdr),
        .opcode,
        .inst4,
        .inst5,
        .inst11,
        .dest,
        .src1,
        .src2,
        .imm4,
        .imm5,
        .offset6,
        .offset9,
        .offset11
    );

    // Register file
    assign storemux_out = storemux_sel ? dest : src2;  // STR reads its source through port b
    assign destmux_out  = destmux_sel ? link_reg : dest;

    always_comb begin
        case (regfilemux_sel)
            rfmux_mdr:   regfilemux_out = mdr;
            rfmux_bradd: regfilemux_out = bradd_out;
            rfmux_pc:    regfilemux_out = pc;
            default:     regfilemux_out = alu_out;
        endcase
    end

    regfile u_regfile (
        .clk,
        .reset,
        .load(load_regfile),
        .in(regfilemux_out),
        .src_a(src1),
        .src_b(storemux_out),
        .dest(destmux_out),
        .reg_a(sr1_out),
        .reg_b(sr2_out)
    );

    // ALU operand select
    always_comb begin
        case (alumux_sel)
            alumux_sext5: alumux_out = sext5;
            alumux_adj6:  alumux_out = adj6;
            alumux_zext4: alumux_out = zext4;
            default:      alumux_out = sr2_out;
        endcase
    end

    alu u_alu (
        .aluop,
        .a(sr1_out),
        .b(alumux_out),
        .f(alu_out)
    );

    // Condition codes
    always_comb begin
        if (regfilemux_out[15]) begin
            gencc = 3'b100;
        end else if (regfilemux_out == 16'h0000) begin
            gencc = 3'b010;
        end else begin
            gencc = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cc <= 3'b010;
        end else if (load_cc) begin
            cc <= gencc;
        end
    end

    assign branch_enable = |(dest & cc);

endmodule : datapath

`default_nettype wire

// File: hdl/control.sv
`timescale 1ns/1ps
`default_nettype none

module control
    import lc3b_types::*;
(
    input  logic            clk,
    input  logic            reset,

    input  lc3b_opcode      opcode,
    input  logic            inst4,
    input  logic            inst5,
    input  logic            inst11,
    input  logic            branch_enable,
    input  logic            mem_resp,

    output logic            load_pc,
    output logic            load_ir,
    output logic            load_regfile,
    output logic            load_mar,
    output logic            load_mdr,
    output logic            load_cc,
    output pcmux_sel_t      pcmux_sel,
    output logic            storemux_sel,
    output logic            destmux_sel,
    output alumux_sel_t     alumux_sel,
    output regfilemux_sel_t regfilemux_sel,
    output logic            marmux_sel,
    output logic            mdrmux_sel,
    output lc3b_aluop       aluop,
    output logic            mem_read,
    output logic            mem_write
);

    typedef enum logic [3:0] {
        s_fetch1,
        s_fetch2,
        s_fetch3,
        s_decode,
        s_alu,
        s_br,
        s_jmp,
        s_jsr1,
        s_jsr2,
        s_lea,
        s_calc_addr,
        s_ldr_mem,
        s_ldr_wb,
        s_str_mdr,
        s_str_mem
    } state_t;

    state_t state, next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_fetch1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            s_fetch1: next_state = s_fetch2;
            s_fetch2: if (mem_resp) next_state = s_fetch3;
            s_fetch3: next_state = s_decode;
            s_decode: begin
                case (opcode)
                    op_add, op_and, op_not, op_shf: next_state = s_alu;
                    op_br:            next_state = s_br;
                    op_jmp:           next_state = s_jmp;
                    op_jsr:           next_state = s_jsr1;
                    op_lea:           next_state = s_lea;
                    op_ldr, op_str:   next_state = s_calc_addr;
                    default:          next_state = s_fetch1;  // Unsupported, treated as a no-op
                endcase
            end
            s_jsr1:      next_state = s_jsr2;
            s_calc_addr: next_state = (opcode == op_ldr) ? s_ldr_mem : s_str_mdr;
            s_ldr_mem:   if (mem_resp) next_state = s_ldr_wb;
            s_str_mdr:   next_state = s_str_mem;
            s_str_mem:   if (mem_resp) next_state = s_fetch1;
            default:     next_state = s_fetch1;
        endcase
    end

    always_comb begin
        load_pc        = 1'b0;
        load_ir        = 1'b0;
        load_regfile   = 1'b0;
        load_mar       = 1'b0;
        load_mdr       = 1'b0;
        load_cc        = 1'b0;
        pcmux_sel      = pcmux_plus2;
        storemux_sel   = 1'b0;
        destmux_sel    = 1'b0;
        alumux_sel     = alumux_reg;
        regfilemux_sel = rfmux_alu;
        marmux_sel     = 1'b0;
        mdrmux_sel     = 1'b0;
        aluop          = alu_add;
        mem_read       = 1'b0;
        mem_write      = 1'b0;

        case (state)
            s_fetch1: begin
                marmux_sel = 1'b1;
                load_mar   = 1'b1;
            end
            s_fetch2: begin
                mem_read   = 1'b1;
                mdrmux_sel = 1'b1;
                load_mdr   = 1'b1;
                load_pc    = mem_resp;  // PC moves on with the instruction word
            end
            s_fetch3: load_ir = 1'b1;
            s_alu: begin
                case (opcode)
                    op_and: aluop = alu_and;
                    op_not: aluop = alu_not;
                    op_shf: aluop = inst4 ? (inst5 ? alu_sra : alu_srl) : alu_sll;
                    default: aluop = alu_add;
                endcase
                if (opcode == op_shf) begin
                    alumux_sel = alumux_zext4;
                end else if (opcode != op_not && inst5) begin
                    alumux_sel = alumux_sext5;
                end
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            s_br: begin
                pcmux_sel = pcmux_branch;
                load_pc   = branch_enable;
            end
            s_jmp: begin
                pcmux_sel = pcmux_base;
                load_pc   = 1'b1;
            end
            s_jsr1: begin
                regfilemux_sel = rfmux_pc;
                destmux_sel    = 1'b1;
                load_regfile   = 1'b1;
            end
            s_jsr2: begin
                pcmux_sel = inst11 ? pcmux_branch : pcmux_base;
                load_pc   = 1'b1;
            end
            s_lea: begin
                regfilemux_sel = rfmux_bradd;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            s_calc_addr: begin
                alumux_sel = alumux_adj6;
                load_mar   = 1'b1;
            end
            s_ldr_mem: begin
                mem_read   = 1'b1;
                mdrmux_sel = 1'b1;
                load_mdr   = 1'b1;
            end
            s_ldr_wb: begin
                regfilemux_sel = rfmux_mdr;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            s_str_mdr: begin
                storemux_sel = 1'b1;
                aluop        = alu_pass;
                load_mdr     = 1'b1;
            end
            s_str_mem: mem_write = 1'b1;
            default: ;
        endcase
    end

endmodule : control

`default_nettype wire

// File: hdl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     reset,
    input  lc3b_word mem_rdata,
    input  logic     mem_resp,
    output lc3b_word mem_address,
    output lc3b_word mem_wdata,
    output logic     mem_read,
    output logic     mem_write
);

    logic            load_pc, load_ir, load_regfile, load_mar, load_mdr, load_cc;
    logic            storemux_sel, destmux_sel, marmux_sel, mdrmux_sel;
    pcmux_sel_t      pcmux_sel;
    alumux_sel_t     alumux_sel;
    regfilemux_sel_t regfilemux_sel;
    lc3b_aluop       aluop;
    lc3b_opcode      opcode;
    logic            inst4, inst5, inst11, branch_enable;

    control u_control (
        .clk,
        .reset,
        .opcode,
        .inst4,
        .inst5,
        .inst11,
        .branch_enable,
        .mem_resp,
        .load_pc,
        .load_ir,
        .load_regfile,
        .load_mar,
        .load_mdr,
        .load_cc,
        .pcmux_sel,
        .storemux_sel,
        .destmux_sel,
        .alumux_sel,
        .regfilemux_sel,
        .marmux_sel,
        .mdrmux_sel,
        .aluop,
        .mem_read,
        .mem_write
    );

    datapath u_datapath (
        .clk,
        .reset,
        .mem_rdata,
        .mem_resp,
        .load_pc,
        .load_ir,
        .load_regfile,
        .load_mar,
        .load_mdr,
        .load_cc,
        .pcmux_sel,
        .storemux_sel,
        .destmux_sel,
        .alumux_sel,
        .regfilemux_sel,
        .marmux_sel,
        .mdrmux_sel,
        .aluop,
        .mem_address,
        .mem_wdata,
        .opcode,
        .inst4,
        .inst5,
        .inst11,
        .branch_enable
    );

endmodule : cpu

`default_nettype wire

// File: sim/cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_handshake_props
    import lc3b_types::*;
(
    input logic     clk,
    input logic     reset,
    input logic     mem_read,
    input logic     mem_write,
    input logic     mem_resp,
    input lc3b_word mem_address,
    input lc3b_word mem_wdata
);

    a_single_request: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    // A pending read keeps its address until the response edge
    a_read_held: assert property (@(posedge clk) disable iff (reset)
        mem_read && !mem_resp |=> mem_read && $stable(mem_address))
        else $error("Read request or address changed before mem_resp");

    a_write_held: assert property (@(posedge clk) disable iff (reset)
        mem_write && !mem_resp |=> mem_write && $stable(mem_address) && $stable(mem_wdata))
        else $error("Write request, address or data changed before mem_resp");

    a_quiet_in_reset: assert property (@(posedge clk)
        $past(reset) |-> !mem_read && !mem_write)
        else $error("Memory request raised during reset");

endmodule : cpu_handshake_props

bind cpu cpu_handshake_props u_handshake_props (
    .clk(clk),
    .reset(reset),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_resp(mem_resp),
    .mem_address(mem_address),
    .mem_wdata(mem_wdata)
);

`default_nettype wire

// File: sim/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
    import lc3b_types::*;
();

    logic     clk;
    logic     reset;
    lc3b_word mem_rdata;
    logic     mem_resp;
    lc3b_word mem_address;
    lc3b_word mem_wdata;
    logic     mem_read;
    logic     mem_write;

    lc3b_word    stim [512];
    lc3b_word    mem [256];
    int          test_base [16];  // Offset of each test record in stim
    lc3b_word    exp_addr [$];
    lc3b_word    exp_data [$];
    logic [31:0] lfsr;
    int          cycle_count;
    int          cycle_limit;
    int          errors;
    int          test_errors;
    int          failed_runs;
    int          store_count;

    cpu uut (
        .clk(clk),
        .reset(reset),
        .mem_rdata(mem_rdata),
        .mem_resp(mem_resp),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_read(mem_read),
        .mem_write(mem_write)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: no halt reached within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic serve_request();
        lc3b_word want_addr;
        lc3b_word want_data;
        assert (mem_address[15:9] == 7'd0 && !mem_address[0]) else begin
            $display("Access outside the memory model at address %h", mem_address);
            test_errors++;
        end
        if (mem_read) begin
            mem_rdata = mem[mem_address[8:1]];
        end else begin
            mem[mem_address[8:1]] = mem_wdata;
            store_count++;
            assert (exp_addr.size() > 0) else begin
                $display("Extra store of %h to %h after the last expected one",
                         mem_wdata, mem_address);
                test_errors++;
            end
            if (exp_addr.size() > 0) begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                assert (mem_address == want_addr) else begin
                    $display("CHECK FAILED mem_address: expected %h, got %h",
                             want_addr, mem_address);
                    test_errors++;
                end
                assert (mem_wdata == want_data) else begin
                    $display("CHECK FAILED mem_wdata: expected %h, got %h",
                             want_data, mem_wdata);
                    test_errors++;
                end
            end
        end
        mem_resp = 1'b1;
    endtask

    task automatic run_test(input int run, input int test, input logic rand_mode);
        int       rec;
        int       wait_left;
        lc3b_word start;
        lc3b_word halt;
        logic     busy;
        logic     halted;
        logic     first_req;

        rec   = test_base[test];
        start = stim[rec];
        halt  = stim[rec + 1];
        for (int i = 0; i < 256; i++) begin
            mem[i] = stim[i];
        end
        // The word at reset_pc becomes a BRnzp to the test's first instruction
        mem[reset_pc[8:1]] = 16'h0e00 | (((start - reset_pc - 16'd2) >> 1) & 16'h01ff);
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < int'(stim[rec + 3]); i++) begin
            exp_addr.push_back(stim[rec + 4 + 2 * i]);
            exp_data.push_back(stim[rec + 5 + 2 * i]);
        end
        test_errors = 0;
        store_count = 0;
        wait_left   = 0;
        busy        = 1'b0;
        halted      = 1'b0;
        first_req   = 1'b1;

        reset    = 1'b1;
        mem_resp = 1'b0;
        repeat (16) begin
            @(posedge clk);
            #2;
            assert (!mem_read && !mem_write) else begin
                $display("Memory request raised during reset");
                test_errors++;
            end
        end
        reset = 1'b0;

        while (!halted) begin
            @(posedge clk);
            #2;
            mem_resp = 1'b0;  // Response is a one cycle pulse
            if ((mem_read || mem_write) && !busy) begin
                busy = 1'b1;
                if (first_req) begin
                    assert (mem_read && !mem_write) else begin
                        $display("First request after reset is not a read");
                        test_errors++;
                    end
                    assert (mem_address == reset_pc) else begin
                        $display("CHECK FAILED mem_address: expected %h, got %h",
                                 reset_pc, mem_address);
                        test_errors++;
                    end
                    first_req = 1'b0;
                end
                if (mem_read && mem_address == halt) begin
                    halted = 1'b1;
                end else if (rand_mode) begin
                    draw_bits(3, wait_left);
                end else begin
                    wait_left = 0;
                end
            end
            if (busy && !halted) begin
                if (wait_left == 0) begin
                    serve_request();
                    busy = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end

        assert (store_count == int'(stim[rec + 3])) else begin
            $display("Saw %0d stores where %0d were expected", store_count, stim[rec + 3]);
            test_errors++;
        end
        errors += test_errors;
        if (test_errors != 0) begin
            failed_runs++;
        end
        $display("Run %0d: test %0d at %h, %s latency, %0d stores, %0d errors",
                 run, test, start, rand_mode ? "random" : "zero-wait", store_count,
                 test_errors);
    endtask

    initial begin : main
        int tests;
        int runs;
        int pos;
        int insts;

        reset       = 1'b1;
        mem_rdata   = 16'h0000;
        mem_resp    = 1'b0;
        lfsr        = 32'hb7fe_e28d;
        errors      = 0;
        failed_runs = 0;
        cycle_count = 0;
        cycle_limit = 0;
        for (int i = 0; i < 512; i++) begin
            stim[i] = 16'hf000 ^ 16'(i);  // Unlisted words decode as TRAP, which the core skips
        end
        $readmemh("sim/cpu_stimulus.txt", stim);

        tests = int'(stim['h100]);
        pos   = 'h101;
        for (int t = 0; t < tests; t++) begin
            test_base[t] = pos;
            pos = pos + 4 + 2 * int'(stim[pos + 3]);
        end
        runs  = int'(stim['h180]);
        insts = 0;
        for (int r = 0; r < runs; r++) begin
            insts += int'(stim[test_base[stim['h181 + 2 * r]] + 2]) + 1;  // Plus the boot branch
        end
        // About 24 cycles per instruction at seven wait states, plus each reset
        cycle_limit = insts * 24 + runs * 40 + 200;

        for (int r = 0; r < runs; r++) begin
            run_test(r, int'(stim['h181 + 2 * r]), stim['h182 + 2 * r][0]);
        end

        $display("Runs %0d, failed runs %0d, errors %0d", runs, failed_runs, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : cpu_tb

`default_nettype wire

// File: sim.f
hdl/lc3b_types.sv
hdl/ir.sv
hdl/regfile.sv
hdl/alu.sv
hdl/datapath.sv
hdl/control.sv
hdl/cpu.sv
sim/cpu_props.sv
sim/cpu_tb.sv

// File: sim/cpu_stimulus.txt
// Hex words for $readmemh, @ gives the word index (byte address / 2)
// Image at 000-0ff; tests at 100: count, then start halt insts stores {addr data}
// Runs at 180: count, then {test mode} with mode 0 zero-wait and 1 random latency
@008
1234 beef 8001
// ALU ops at 0x040
@020
1227 143d 1642 7610 58be 7811 5b01 7a12
9c7f 7c13 d245 7214 d592 7415 d7b3 7616
0fff
// LDR and STR copy at 0x070
@038
e3cf 6440 6641 6842 7450 7651 787f 0fff
// BR, JSR and JMP at 0x090
@048
123f 0601 7210 0801 7011 1420 0402 7012
7013 4803 1625 7615 0fff 7e14 c1c0
// LEA at 0x0c0
@060
e205 7210 e5ec 7411 0fff
@100
0004
0040 0060 0011 0007
0020 0004 0022 fffc 0024 0004 0026 fff8
0028 00e0 002a 3ffe 002c ffff
0070 007e 0007 0003
0030 1234 0032 beef 000e 8001
0090 00a8 000c 0003
0020 ffff 0028 00a4 002a 0005
00c0 00c8 0005 0002
0020 00cc 0022 009e
@180
0008
0000 0000 0001 0000 0002 0000 0003 0000
0000 0001 0001 0001 0002 0001 0003 0001
